// ==== filelist.f ====
verilog/axicb_cfg_pkg.sv
verilog/axicb_chan_pkg.sv
verilog/axicb_slv_switch.sv
verilog/axicb_mst_switch.sv
verilog/axicb_switch_top.sv
tb/axicb_switch_asserts.sv
tb/axicb_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module axicb_switch_tb --Mdir obj_dir -o sim_axicb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_axicb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb/axicb_switch_tb.sv ====
// Testbench for the AXI4-lite read crossbar
// Master drivers and slave models around the DUT, with a scoreboard per master
`timescale 1ns/10ps

module axicb_switch_tb;

    import axicb_cfg_pkg::*;
    import axicb_chan_pkg::*;

    localparam int RESET_CYCLES = 8;
    // Reads over all tests, sizes the watchdog
    localparam int NUM_READS    = 306;

    logic                     aclk = 1'b0;
    logic                     i_reset;
    mst_vec_t                 mst_arvalid;
    mst_vec_t                 mst_arready;
    ar_req_t  [MST_NB-1:0]    mst_ar;
    mst_vec_t                 mst_rvalid;
    mst_vec_t                 mst_rready;
    r_resp_t  [MST_NB-1:0]    mst_r;
    slv_vec_t                 slv_arvalid;
    slv_vec_t                 slv_arready;
    ar_req_t  [SLV_NB-1:0]    slv_ar;
    slv_vec_t                 slv_rvalid;
    slv_vec_t                 slv_rready;
    r_resp_t  [SLV_NB-1:0]    slv_r;

    integer   seed = 65496;
    logic [31:0] drv_rnd;
    int       errors = 0;
    int       checks = 0;
    int       tests_run = 0;
    logic     rand_rready = 1'b0;
    logic     log_grants = 1'b0;
    // Drivers start one edge after reset is released
    logic     model_enable = 1'b0;

    // Pending reads per master, expected R per master, accepted AR per slave
    ar_req_t  mst_q[MST_NB][$];
    r_resp_t  exp_q[MST_NB][$];
    ar_req_t  slv_pend[SLV_NB][$];
    mst_idx_t grant_log[$];
    int       slv_wait[SLV_NB];
    int       issued[MST_NB];
    int       received[MST_NB];

    // Handshakes seen just before the coming rising edge
    mst_vec_t              mst_ar_done = '0;
    slv_vec_t              slv_ar_done = '0;
    slv_vec_t              slv_r_done = '0;
    ar_req_t  [SLV_NB-1:0] slv_ar_cap;

    always #2 aclk = ~aclk;

    axicb_switch_top i_axicb_switch_top (
        .aclk          (aclk),
        .i_reset       (i_reset),
        .i_mst_arvalid (mst_arvalid),
        .o_mst_arready (mst_arready),
        .i_mst_ar      (mst_ar),
        .o_mst_rvalid  (mst_rvalid),
        .i_mst_rready  (mst_rready),
        .o_mst_r       (mst_r),
        .o_slv_arvalid (slv_arvalid),
        .i_slv_arready (slv_arready),
        .o_slv_ar      (slv_ar),
        .i_slv_rvalid  (slv_rvalid),
        .o_slv_rready  (slv_rready),
        .i_slv_r       (slv_r)
    );

    bind axicb_switch_top axicb_switch_asserts i_axicb_switch_asserts (
        .aclk          (aclk),
        .i_reset       (i_reset),
        .o_slv_arvalid (o_slv_arvalid),
        .i_slv_arready (i_slv_arready),
        .o_slv_ar      (o_slv_ar),
        .o_mst_rvalid  (o_mst_rvalid),
        .o_mst_r       (o_mst_r)
    );

    ///////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks
    ///////////////////////////////////////////////////////////////////////

    // Slave index from the address map in the top byte, XOR the address
    function automatic data_t ref_read_data(input addr_t addr);
        slv_idx_t slv;
        if (32'(addr) >= SLV1_START_ADDR && 32'(addr) <= SLV1_END_ADDR) begin
            slv = 1'b1;
        end else begin
            slv = 1'b0;
        end
        return {8'(slv), 24'h0} ^ data_t'(addr);
    endfunction

    task automatic check_data(input int mst, input data_t got, input data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t ns: master %0d data %h, expected %h", $time, mst, got, want);
        end
    endtask

    task automatic check_id(input int mst, input id_t got, input id_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t ns: master %0d id %h, expected %h", $time, mst, got, want);
        end
    endtask

    task automatic check_resp(input int mst, input resp_t got, input resp_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t ns: master %0d resp %b, expected %b", $time, mst, got, want);
        end
    endtask

    task automatic expect_quiet(input slv_vec_t arv, input mst_vec_t rv);
        checks++;
        if (arv !== '0 || rv !== '0) begin
            errors++;
            $display("** Error at %0t ns: arvalid %b rvalid %b, expected all low", $time, arv, rv);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Master drivers and slave models
    ///////////////////////////////////////////////////////////////////////

    always begin : drive_and_model
        ar_req_t head;
        @(negedge aclk);
        if (model_enable) begin
            for (int m = 0; m < MST_NB; m++) begin
                if (mst_ar_done[m]) begin
                    mst_arvalid[m] = 1'b0;
                    void'(mst_q[m].pop_front());
                end
                if (!mst_arvalid[m] && mst_q[m].size() > 0) begin
                    mst_ar[m]      = mst_q[m][0];
                    mst_arvalid[m] = 1'b1;
                end
                drv_rnd       = $random(seed);
                mst_rready[m] = rand_rready ? drv_rnd[0] : 1'b1;
            end
            for (int s = 0; s < SLV_NB; s++) begin
                if (slv_ar_done[s]) begin
                    slv_pend[s].push_back(slv_ar_cap[s]);
                end
                if (slv_r_done[s]) begin
                    slv_rvalid[s] = 1'b0;
                    void'(slv_pend[s].pop_front());
                end
                drv_rnd        = $random(seed);
                slv_arready[s] = drv_rnd[0] | drv_rnd[1];
                // Responses in order, after a short random delay
                if (!slv_rvalid[s] && slv_pend[s].size() > 0) begin
                    if (slv_wait[s] == 0) begin
                        head            = slv_pend[s][0];
                        slv_r[s].id     = head.id;
                        slv_r[s].data   = {8'(s), 24'h0} ^ data_t'(head.addr);
                        slv_r[s].resp   = RESP_OKAY;
                        slv_rvalid[s]   = 1'b1;
                        slv_wait[s]     = int'(drv_rnd[3:2]);
                    end else begin
                        slv_wait[s]--;
                    end
                end
            end
        end
        #1;
        for (int m = 0; m < MST_NB; m++) begin
            mst_ar_done[m] = mst_arvalid[m] && mst_arready[m];
        end
        for (int s = 0; s < SLV_NB; s++) begin
            slv_ar_done[s] = slv_arvalid[s] && slv_arready[s];
            slv_ar_cap[s]  = slv_ar[s];
            slv_r_done[s]  = slv_rvalid[s] && slv_rready[s];
        end
        if (log_grants && slv_ar_done[0]) begin
            grant_log.push_back(slv_ar[0].id[AXI_ID_W-1]);
        end
        model_enable = !i_reset;
    end

    ///////////////////////////////////////////////////////////////////////
    // Scoreboard
    ///////////////////////////////////////////////////////////////////////

    always begin : compare_responses
        r_resp_t want;
        @(negedge aclk);
        #1;
        if (!i_reset) begin
            for (int m = 0; m < MST_NB; m++) begin
                if (mst_arvalid[m] && mst_arready[m]) begin
                    want.id   = mst_ar[m].id;
                    want.data = ref_read_data(mst_ar[m].addr);
                    want.resp = RESP_OKAY;
                    exp_q[m].push_back(want);
                    issued[m]++;
                end
                if (mst_rvalid[m] && mst_rready[m]) begin
                    received[m]++;
                    if (exp_q[m].size() == 0) begin
                        errors++;
                        $display("Master %0d got an R beat at %0t ns with no read open", m, $time);
                    end else begin
                        want = exp_q[m].pop_front();
                        check_data(m, mst_r[m].data, want.data);
                        check_id(m, mst_r[m].id, want.id);
                        check_resp(m, mst_r[m].resp, want.resp);
                    end
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Test sequence
    ///////////////////////////////////////////////////////////////////////

    function automatic addr_t slave_addr(input int slv);
        logic [31:0] rnd;
        rnd = $random(seed);
        return {slv_idx_t'(slv), rnd[11:0]};
    endfunction

    // ID top bit names the issuing master
    task automatic queue_read(input int mst, input addr_t addr);
        logic [31:0] rnd;
        ar_req_t     req;
        rnd      = $random(seed);
        req.id   = {mst_idx_t'(mst), rnd[AXI_ID_W-2:0]};
        req.addr = addr;
        mst_q[mst].push_back(req);
    endtask

    task automatic wait_idle();
        logic busy;
        do begin
            @(posedge aclk);
            busy = (mst_arvalid != '0);
            for (int m = 0; m < MST_NB; m++) begin
                busy = busy || mst_q[m].size() > 0 || exp_q[m].size() > 0;
            end
        end while (busy);
    endtask

    task automatic end_test(input string name, input int err_mark);
        tests_run++;
        $display("%-32s %s, %0d errors", name, (errors == err_mark) ? "passed" : "failed",
                 errors - err_mark);
    endtask

    initial begin : run_tests
        logic [31:0] rnd;
        int          err_mark;
        i_reset     = 1'b1;
        mst_arvalid = '0;
        mst_ar      = '0;
        mst_rready  = '0;
        slv_arready = '0;
        slv_rvalid  = '0;
        slv_r       = '0;
        for (int i = 0; i < SLV_NB; i++) begin
            slv_wait[i] = 0;
        end
        repeat (RESET_CYCLES) @(negedge aclk);
        i_reset = 1'b0;

        err_mark = errors;
        @(negedge aclk);
        #1;
        expect_quiet(slv_arvalid, mst_rvalid);
        end_test("1 quiet after reset", err_mark);

        err_mark = errors;
        @(posedge aclk);
        for (int m = 0; m < MST_NB; m++) begin
            for (int s = 0; s < SLV_NB; s++) begin
                queue_read(m, slave_addr(s));
            end
        end
        wait_idle();
        end_test("2 each master to each slave", err_mark);

        // Both masters on slave 0, grants at the slave must alternate
        err_mark   = errors;
        log_grants = 1'b1;
        for (int r = 0; r < 6; r++) begin
            // Lone read first, so the contention winner flips every round
            @(posedge aclk);
            queue_read(r % 2, slave_addr(0));
            wait_idle();
            @(posedge aclk);
            queue_read(0, slave_addr(0));
            queue_read(1, slave_addr(0));
            wait_idle();
        end
        log_grants = 1'b0;
        if (grant_log.size() != 18) begin
            errors++;
            $display("Slave 0 saw %0d requests in the contention test, not 18", grant_log.size());
        end
        for (int i = 1; i < grant_log.size(); i++) begin
            if (grant_log[i] == grant_log[i-1]) begin
                errors++;
                $display("Slave 0 granted master %0d twice in a row", grant_log[i]);
            end
        end
        end_test("3 same slave contention", err_mark);

        err_mark = errors;
        for (int r = 0; r < 2; r++) begin
            @(posedge aclk);
            queue_read(0, slave_addr(r));
            queue_read(1, slave_addr(1 - r));
            wait_idle();
        end
        end_test("4 different slaves", err_mark);

        err_mark    = errors;
        rand_rready = 1'b1;
        @(posedge aclk);
        for (int m = 0; m < MST_NB; m++) begin
            issued[m]   = 0;
            received[m] = 0;
        end
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            queue_read(0, addr_t'(rnd[12:0]));
            queue_read(1, addr_t'(rnd[28:16]));
        end
        wait_idle();
        for (int m = 0; m < MST_NB; m++) begin
            if (issued[m] != 40 || received[m] != 40) begin
                errors++;
                $display("Master %0d issued %0d reads and got %0d R beats, 40 each expected",
                         m, issued[m], received[m]);
            end
        end
        end_test("5 random back-pressure", err_mark);

        err_mark = errors;
        @(posedge aclk);
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            queue_read(int'(rnd[5]), addr_t'(rnd[20:8]));
        end
        wait_idle();
        end_test("6 random reads", err_mark);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog, 200 cycles per read
    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_READS * 200) @(posedge aclk);
        $display("Timeout: reads still open after %0d cycles", NUM_READS * 200);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tb/axicb_switch_asserts.sv ====
// Handshake and routing checks bound into the read crossbar
`timescale 1ns/10ps

module axicb_switch_asserts (
    input logic                                            aclk,
    input logic                                            i_reset,
    input axicb_cfg_pkg::slv_vec_t                         o_slv_arvalid,
    input axicb_cfg_pkg::slv_vec_t                         i_slv_arready,
    input axicb_chan_pkg::ar_req_t [axicb_cfg_pkg::SLV_NB-1:0] o_slv_ar,
    input axicb_cfg_pkg::mst_vec_t                         o_mst_rvalid,
    input axicb_chan_pkg::r_resp_t [axicb_cfg_pkg::MST_NB-1:0] o_mst_r
);

    import axicb_cfg_pkg::*;
    import axicb_chan_pkg::*;

    // AR held with a stable payload until the slave takes it
    for (genvar s = 0; s < SLV_NB; s++) begin : g_ar_hold
        a_ar_hold: assert property (@(posedge aclk) disable iff (i_reset)
            o_slv_arvalid[s] && !i_slv_arready[s] |=> o_slv_arvalid[s] && $stable(o_slv_ar[s]))
            else $error("AR toward slave %0d dropped or changed before arready", s);
    end

    // R only reaches the master named in the ID
    for (genvar m = 0; m < MST_NB; m++) begin : g_r_owner
        a_r_owner: assert property (@(posedge aclk) disable iff (i_reset)
            o_mst_rvalid[m] |-> o_mst_r[m].id[AXI_ID_W-1] == mst_idx_t'(m))
            else $error("R for another master delivered to master %0d", m);
    end

    a_reset_quiet: assert property (@(posedge aclk)
        i_reset && $past(i_reset) |-> o_slv_arvalid == '0 && o_mst_rvalid == '0)
        else $error("arvalid or rvalid high during reset");

endmodule

// ==== verilog/axicb_switch_top.sv ====
// AXI4-lite read crossbar, two masters by two slaves
// Switch instances plus the transpose of the valid/ready matrices
`timescale 1ns/10ps

module axicb_switch_top (
    input  logic                                            aclk,
    input  logic                                            i_reset,
    // Master ports
    input  axicb_cfg_pkg::mst_vec_t                         i_mst_arvalid,
    output axicb_cfg_pkg::mst_vec_t                         o_mst_arready,
    input  axicb_chan_pkg::ar_req_t [axicb_cfg_pkg::MST_NB-1:0] i_mst_ar,
    output axicb_cfg_pkg::mst_vec_t                         o_mst_rvalid,
    input  axicb_cfg_pkg::mst_vec_t                         i_mst_rready,
    output axicb_chan_pkg::r_resp_t [axicb_cfg_pkg::MST_NB-1:0] o_mst_r,
    // Slave ports
    output axicb_cfg_pkg::slv_vec_t                         o_slv_arvalid,
    input  axicb_cfg_pkg::slv_vec_t                         i_slv_arready,
    output axicb_chan_pkg::ar_req_t [axicb_cfg_pkg::SLV_NB-1:0] o_slv_ar,
    input  axicb_cfg_pkg::slv_vec_t                         i_slv_rvalid,
    output axicb_cfg_pkg::slv_vec_t                         o_slv_rready,
    input  axicb_chan_pkg::r_resp_t [axicb_cfg_pkg::SLV_NB-1:0] i_slv_r
);

    import axicb_cfg_pkg::*;
    import axicb_chan_pkg::*;

    // Per-master rows, one bit per slave
    slv_vec_t [MST_NB-1:0] ss_arvalid;
    slv_vec_t [MST_NB-1:0] ss_arready;
    slv_vec_t [MST_NB-1:0] ss_rvalid;
    slv_vec_t [MST_NB-1:0] ss_rready;
    ar_req_t  [MST_NB-1:0] ss_ar;

    // Per-slave rows, one bit per master
    mst_vec_t [SLV_NB-1:0] ms_arvalid;
    mst_vec_t [SLV_NB-1:0] ms_arready;
    mst_vec_t [SLV_NB-1:0] ms_rvalid;
    mst_vec_t [SLV_NB-1:0] ms_rready;
    r_resp_t  [SLV_NB-1:0] ms_r;

    ///////////////////////////////////////////////////////////////////////
    // One switch per master
    ///////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < MST_NB; m++) begin : g_slv_switch
        axicb_slv_switch slv_switch (
            .aclk          (aclk),
            .i_reset       (i_reset),
            .i_arvalid     (i_mst_arvalid[m]),
            .o_arready     (o_mst_arready[m]),
            .i_ar          (i_mst_ar[m]),
            .o_rvalid      (o_mst_rvalid[m]),
            .i_rready      (i_mst_rready[m]),
            .o_r           (o_mst_r[m]),
            .o_slv_arvalid (ss_arvalid[m]),
            .i_slv_arready (ss_arready[m]),
            .o_slv_ar      (ss_ar[m]),
            .i_slv_rvalid  (ss_rvalid[m]),
            .o_slv_rready  (ss_rready[m]),
            .i_slv_r       (ms_r)
        );
    end

    ///////////////////////////////////////////////////////////////////////
    // Transpose master-by-slave handshakes
    ///////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : g_reorder_slv
        for (genvar m = 0; m < MST_NB; m++) begin : g_reorder_mst
            assign ms_arvalid[s][m] = ss_arvalid[m][s];
            assign ms_rready[s][m]  = ss_rready[m][s];
            assign ss_arready[m][s] = ms_arready[s][m];
            assign ss_rvalid[m][s]  = ms_rvalid[s][m];
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // One switch per slave
    ///////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : g_mst_switch
        axicb_mst_switch mst_switch (
            .aclk          (aclk),
            .i_reset       (i_reset),
            .i_arvalid     (ms_arvalid[s]),
            .o_arready     (ms_arready[s]),
            .i_ar          (ss_ar),
            .o_rvalid      (ms_rvalid[s]),
            .i_rready      (ms_rready[s]),
            .o_r           (ms_r[s]),
            .o_slv_arvalid (o_slv_arvalid[s]),
            .i_slv_arready (i_slv_arready[s]),
            .o_slv_ar      (o_slv_ar[s]),
            .i_slv_rvalid  (i_slv_rvalid[s]),
            .o_slv_rready  (o_slv_rready[s]),
            .i_slv_r       (i_slv_r[s])
        );
    end

endmodule

// ==== verilog/axicb_mst_switch.sv ====
// Per-slave switch of the read crossbar
// Round-robin AR arbitration into a request register, R routed back by ID
`timescale 1ns/10ps

module axicb_mst_switch (
    input  logic                                            aclk,
    input  logic                                            i_reset,
    // From the master-side switches
    input  axicb_cfg_pkg::mst_vec_t                         i_arvalid,
    output axicb_cfg_pkg::mst_vec_t                         o_arready,
    input  axicb_chan_pkg::ar_req_t [axicb_cfg_pkg::MST_NB-1:0] i_ar,
    output axicb_cfg_pkg::mst_vec_t                         o_rvalid,
    input  axicb_cfg_pkg::mst_vec_t                         i_rready,
    output axicb_chan_pkg::r_resp_t                         o_r,
    // To the slave
    output logic                                            o_slv_arvalid,
    input  logic                                            i_slv_arready,
    output axicb_chan_pkg::ar_req_t                         o_slv_ar,
    input  logic                                            i_slv_rvalid,
    output logic                                            o_slv_rready,
    input  axicb_chan_pkg::r_resp_t                         i_slv_r
);

    import axicb_cfg_pkg::*;
    import axicb_chan_pkg::*;

    mst_idx_t rr_ptr;
    mst_idx_t cand;
    mst_idx_t grant_idx;
    logic     any_req;
    logic     can_load;
    logic     load;
    ar_req_t  req_q;
    logic     req_vld_q;
    mst_idx_t rsp_mst;

    ///////////////////////////////////////////////////////////////////////
    // Round-robin arbiter
    ///////////////////////////////////////////////////////////////////////

    // Scan from the farthest candidate back to the pointer,
    // so the closest requester wins
    always_comb begin
        any_req   = 1'b0;
        grant_idx = rr_ptr;
        cand      = rr_ptr;
        for (int k = MST_NB - 1; k >= 0; k--) begin
            cand = rr_ptr + mst_idx_t'(k);
            if (i_arvalid[cand]) begin
                any_req   = 1'b1;
                grant_idx = cand;
            end
        end
    end

    // Register empty, or emptying this cycle
    assign can_load = !req_vld_q || i_slv_arready;
    assign load     = any_req && can_load;

    always_comb begin
        o_arready = '0;
        if (load) begin
            o_arready[grant_idx] = 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Request register toward the slave
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            req_vld_q <= 1'b0;
            rr_ptr    <= '0;
        end else if (load) begin
            req_vld_q <= 1'b1;
            // Winner goes to the back of the line
            rr_ptr    <= mst_idx_t'(grant_idx + 1'b1);
        end else if (i_slv_arready) begin
            req_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            req_q <= i_ar[grant_idx];
        end
    end

    assign o_slv_arvalid = req_vld_q;
    assign o_slv_ar      = req_q;

    ///////////////////////////////////////////////////////////////////////
    // Response routing
    ///////////////////////////////////////////////////////////////////////

    // Owner of the response sits in the ID's top bit
    assign rsp_mst = mst_idx_t'(i_slv_r.id[AXI_ID_W-1]);

    always_comb begin
        o_rvalid = '0;
        if (i_slv_rvalid) begin
            o_rvalid[rsp_mst] = 1'b1;
        end
    end

    assign o_r          = i_slv_r;
    assign o_slv_rready = i_rready[rsp_mst];

endmodule

// ==== verilog/axicb_slv_switch.sv ====
// Per-master switch of the read crossbar
// Decodes the AR address, tracks the one outstanding read and collects R
`timescale 1ns/10ps

module axicb_slv_switch (
    input  logic                                            aclk,
    input  logic                                            i_reset,
    // From the master
    input  logic                                            i_arvalid,
    output logic                                            o_arready,
    input  axicb_chan_pkg::ar_req_t                         i_ar,
    output logic                                            o_rvalid,
    input  logic                                            i_rready,
    output axicb_chan_pkg::r_resp_t                         o_r,
    // Toward the slave-side switches
    output axicb_cfg_pkg::slv_vec_t                         o_slv_arvalid,
    input  axicb_cfg_pkg::slv_vec_t                         i_slv_arready,
    output axicb_chan_pkg::ar_req_t                         o_slv_ar,
    input  axicb_cfg_pkg::slv_vec_t                         i_slv_rvalid,
    output axicb_cfg_pkg::slv_vec_t                         o_slv_rready,
    input  axicb_chan_pkg::r_resp_t [axicb_cfg_pkg::SLV_NB-1:0] i_slv_r
);

    import axicb_cfg_pkg::*;
    import axicb_chan_pkg::*;

    typedef enum logic {
        IDLE,
        WAIT_R
    } state_t;

    state_t   state;
    slv_idx_t tgt_q;
    slv_vec_t slv_hit;
    slv_idx_t dec_slv;
    logic     ar_hsk;
    logic     r_hsk;

    ///////////////////////////////////////////////////////////////////////
    // Address decode
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        slv_hit[0] = (i_ar.addr >= SLV0_START_ADDR) && (i_ar.addr <= SLV0_END_ADDR);
        slv_hit[1] = (i_ar.addr >= SLV1_START_ADDR) && (i_ar.addr <= SLV1_END_ADDR);
    end

    // The map is complete, so one range always hits
    assign dec_slv = slv_hit[1] ? slv_idx_t'(1) : slv_idx_t'(0);

    ///////////////////////////////////////////////////////////////////////
    // AR forwarding
    ///////////////////////////////////////////////////////////////////////

    // Request only toward the decoded slave, never while a read is open
    assign o_slv_arvalid = (state == IDLE && i_arvalid) ? slv_hit : '0;
    assign o_slv_ar      = i_ar;
    assign o_arready     = (state == IDLE) && i_slv_arready[dec_slv];

    assign ar_hsk = i_arvalid && o_arready;

    ///////////////////////////////////////////////////////////////////////
    // R collection from the targeted slave
    ///////////////////////////////////////////////////////////////////////

    assign o_rvalid = (state == WAIT_R) && i_slv_rvalid[tgt_q];
    assign o_r      = i_slv_r[tgt_q];

    always_comb begin
        o_slv_rready = '0;
        if (state == WAIT_R) begin
            o_slv_rready[tgt_q] = i_rready;
        end
    end

    assign r_hsk = o_rvalid && i_rready;

    // One outstanding read per master
    always_ff @(posedge aclk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_hsk) begin
                        state <= WAIT_R;
                    end
                end
                WAIT_R: begin
                    if (r_hsk) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Slave that owes the response
    always_ff @(posedge aclk) begin
        if (ar_hsk) begin
            tgt_q <= dec_slv;
        end
    end

endmodule

// ==== verilog/axicb_chan_pkg.sv ====
// AXI4-lite read channel definitions
// Field widths, field types and the AR and R payload structs
package axicb_chan_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Field widths
    ///////////////////////////////////////////////////////////////////////

    localparam int AXI_ADDR_W = 13;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32;

    // Response code, only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [AXI_ADDR_W-1:0] addr_t;
    // Top bit holds the index of the issuing master
    typedef logic [AXI_ID_W-1:0]   id_t;
    typedef logic [AXI_DATA_W-1:0] data_t;
    typedef logic [1:0]            resp_t;

    ///////////////////////////////////////////////////////////////////////
    // Channel payloads
    ///////////////////////////////////////////////////////////////////////

    // AR channel, 17 bits
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } ar_req_t;

    // R channel, 38 bits
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
    } r_resp_t;

endpackage

// ==== verilog/axicb_cfg_pkg.sv ====
// AXI4-lite read crossbar configuration
// Topology, slave address map and index types
package axicb_cfg_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Topology
    ///////////////////////////////////////////////////////////////////////

    localparam int MST_NB = 2;
    localparam int SLV_NB = 2;

    ///////////////////////////////////////////////////////////////////////
    // Address map, two contiguous ranges over the whole space
    ///////////////////////////////////////////////////////////////////////

    localparam int unsigned SLV0_START_ADDR = 0;
    localparam int unsigned SLV0_END_ADDR   = 4095;
    localparam int unsigned SLV1_START_ADDR = 4096;
    localparam int unsigned SLV1_END_ADDR   = 8191;

    // Index of one master or one slave
    typedef logic [0:0] mst_idx_t;
    typedef logic [0:0] slv_idx_t;

    // One bit per agent, for valid/ready vectors
    typedef logic [MST_NB-1:0] mst_vec_t;
    typedef logic [SLV_NB-1:0] slv_vec_t;

endpackage
